// File: hdl/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control #(
  parameter rv_core_pkg::word_t reset_pc = rv_core_pkg::default_reset_pc
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     mem_ack,
  input  wire rv_core_pkg::word_t mem_rdata,
  input  wire rv_core_pkg::word_t sum,
  input  wire rv_core_pkg::word_t next_pc,
  input  wire rv_core_pkg::word_t link,
  input  wire rv_core_pkg::word_t load_data,
  input  wire rv_core_pkg::word_t store_data,
  input  wire rv_core_pkg::strb_t store_strb,
  output logic                    mem_req,
  output logic                    mem_we,
  output rv_core_pkg::word_t      mem_addr,
  output rv_core_pkg::word_t      mem_wdata,
  output rv_core_pkg::strb_t      mem_wstrb,
  output rv_core_pkg::word_t      inst,
  output rv_core_pkg::funct3_t    funct3,
  output rv_core_pkg::reg_addr_t  rs1_addr,
  output rv_core_pkg::reg_addr_t  rs2_addr,
  output rv_core_pkg::reg_addr_t  rd_addr,
  output logic                    reg_we,
  output rv_core_pkg::wb_sel_e    wb_sel,
  output rv_core_pkg::word_t      rd_data,
  output logic                    use_pc_a,
  output logic                    use_imm_b,
  output logic                    subtract,
  output logic                    is_branch,
  output logic                    is_jump,
  output rv_core_pkg::word_t      pc,
  output logic                    halted
);
  import rv_core_pkg::*;

  typedef enum logic [2:0] {
    s_fetch_req,
    s_fetch_rel,
    s_execute,
    s_data_req,
    s_data_rel,
    s_writeback,
    s_halted
  } state_e;

  state_e  state;
  opcode_e opcode;
  word_t   load_q;      // aligned load result held past ack
  logic    rd_write;    // execute-cycle register write
  logic    stop;        // ebreak or unknown opcode
  logic    is_load;
  logic    is_store;
  logic    boot_fetch;
  logic    fetch_done;
  logic    data_launch;
  logic    data_done;
  logic    retire;

  assign opcode   = opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign rd_addr  = inst[11:7];
  assign rs2_addr = inst[24:20];
  // lui has immediate bits in the rs1 field, read x0 so sum = imm
  assign rs1_addr = (opcode == op_lui) ? '0 : inst[19:15];
  assign subtract = (opcode == op_reg) && (funct3 == 3'b000) && (inst[31:25] == 7'b010_0000);
  assign is_load  = (opcode == op_load);
  assign is_store = (opcode == op_store);

  always_comb begin
    use_pc_a  = 1'b0;
    use_imm_b = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    rd_write  = 1'b0;
    wb_sel    = wb_alu;
    stop      = 1'b0;
    case (opcode)
      op_reg: rd_write = 1'b1;
      op_imm, op_lui: begin
        use_imm_b = 1'b1;
        rd_write  = 1'b1;
      end
      op_auipc: begin
        use_pc_a  = 1'b1;
        use_imm_b = 1'b1;
        rd_write  = 1'b1;
      end
      op_jal: begin
        use_pc_a  = 1'b1;
        use_imm_b = 1'b1;
        is_jump   = 1'b1;
        rd_write  = 1'b1;
        wb_sel    = wb_link;
      end
      op_jalr: begin
        use_imm_b = 1'b1;
        is_jump   = 1'b1;
        rd_write  = 1'b1;
        wb_sel    = wb_link;
      end
      op_branch: begin
        use_pc_a  = 1'b1;   // target is pc + imm
        use_imm_b = 1'b1;
        is_branch = 1'b1;
      end
      op_load: begin
        use_imm_b = 1'b1;
        wb_sel    = wb_load;  // written in s_writeback
      end
      op_store: use_imm_b = 1'b1;
      default: stop = 1'b1;   // op_system and anything unknown
    endcase
  end

  always_comb begin
    case (wb_sel)
      wb_link: rd_data = link;
      wb_load: rd_data = load_q;
      default: rd_data = sum;
    endcase
  end

  // handshake events
  assign boot_fetch  = (state == s_fetch_req) && !mem_req && !mem_ack;
  assign fetch_done  = (state == s_fetch_req) && mem_req && mem_ack;
  assign data_launch = (state == s_execute) && (is_load || is_store);
  assign data_done   = (state == s_data_req) && mem_ack;
  assign retire      = ((state == s_execute) && !stop && !is_load && !is_store) ||
                       (state == s_writeback);

  assign reg_we = ((state == s_execute) && rd_write) || ((state == s_writeback) && is_load);
  assign halted = (state == s_halted) || ((state == s_execute) && stop);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_fetch_req;  // request goes up on the first edge out of reset
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      mem_wstrb <= '0;
      pc        <= reset_pc;
    end else begin
      if (boot_fetch || retire || data_launch) begin
        mem_req <= 1'b1;
      end else if (fetch_done || data_done) begin
        mem_req <= 1'b0;
      end
      if (retire) begin
        pc        <= next_pc;
        mem_we    <= 1'b0;       // next access is a fetch
        mem_wstrb <= '0;
      end else if (data_launch) begin
        mem_we    <= is_store;
        mem_wstrb <= is_store ? store_strb : '0;
      end
      case (state)
        s_fetch_req: if (fetch_done) state <= s_fetch_rel;
        s_fetch_rel: if (!mem_ack) state <= s_execute;
        s_execute: begin
          if (stop) begin
            state <= s_halted;
          end else if (data_launch) begin
            state <= s_data_req;
          end else begin
            state <= s_fetch_req;
          end
        end
        s_data_req: if (data_done) state <= s_data_rel;
        s_data_rel: if (!mem_ack) state <= s_writeback;
        s_writeback: state <= s_fetch_req;
        default: state <= s_halted;  // held until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      inst <= mem_rdata;
    end
    if (data_done) begin
      load_q <= load_data;
    end
    if (boot_fetch) begin
      mem_addr <= pc;
    end else if (retire) begin
      mem_addr <= next_pc;
    end else if (data_launch) begin
      mem_addr <= {sum[xlen-1:2], 2'b00};  // word address, lanes picked by strobes
    end
    if (data_launch) begin
      mem_wdata <= store_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire rv_core_pkg::word_t   pc,
  input  wire rv_core_pkg::word_t   rs1_data,
  input  wire rv_core_pkg::word_t   rs2_data,
  input  wire rv_core_pkg::word_t   imm,
  input  wire rv_core_pkg::funct3_t funct3,
  input  wire                       use_pc_a,
  input  wire                       use_imm_b,
  input  wire                       subtract,
  input  wire                       is_branch,
  input  wire                       is_jump,
  output rv_core_pkg::word_t        sum,
  output rv_core_pkg::word_t        next_pc,
  output rv_core_pkg::word_t        link
);
  import rv_core_pkg::*;

  word_t          op_a;
  word_t          op_b;
  word_t          op_b_inv;
  logic [xlen:0]  diff;      // rs1 - rs2 with borrow out on top
  logic           eq;
  logic           lt;
  logic           ltu;
  logic           take_branch;

  assign op_a     = use_pc_a ? pc : rs1_data;
  assign op_b     = use_imm_b ? imm : rs2_data;
  assign op_b_inv = op_b ^ {xlen{subtract}};  // two's complement via carry-in
  assign sum      = op_a + op_b_inv + {{(xlen-1){1'b0}}, subtract};
  assign link     = pc + 32'd4;

  assign diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign eq   = (rs1_data == rs2_data);
  assign ltu  = diff[xlen];
  // signs differ: rs1 negative means less
  assign lt   = (rs1_data[xlen-1] != rs2_data[xlen-1]) ? rs1_data[xlen-1] : diff[xlen-1];

  always_comb begin
    case (funct3)
      f3_beq:  take_branch = eq;
      f3_bne:  take_branch = !eq;
      f3_blt:  take_branch = lt;
      f3_bge:  take_branch = !lt;
      f3_bltu: take_branch = ltu;
      f3_bgeu: take_branch = !ltu;
      default: take_branch = 1'b0;
    endcase
    take_branch = take_branch && is_branch;
  end

  always_comb begin
    if (is_jump && !use_pc_a) begin
      next_pc = {sum[xlen-1:1], 1'b0};   // jalr
    end else if (is_jump || take_branch) begin
      next_pc = sum;
    end else begin
      next_pc = link;
    end
  end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  wire rv_core_pkg::word_t inst,
  output rv_core_pkg::word_t      imm
);
  import rv_core_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};  // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // format follows the opcode field
  always_comb begin
    case (inst[6:0])
      op_imm, op_load, op_jalr: imm = imm_i;
      op_store:                 imm = imm_s;
      op_branch:                imm = imm_b;
      op_lui, op_auipc:         imm = imm_u;
      op_jal:                   imm = imm_j;
      default:                  imm = '0;  // register ops, system
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/load_store_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_align (
  input  wire rv_core_pkg::funct3_t funct3,
  input  wire rv_core_pkg::word_t   addr,
  input  wire rv_core_pkg::word_t   rs2_data,
  input  wire rv_core_pkg::word_t   mem_rdata,
  output rv_core_pkg::word_t        store_data,
  output rv_core_pkg::strb_t        store_strb,
  output rv_core_pkg::word_t        load_data
);
  import rv_core_pkg::*;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // store side, misaligned leaves strobes at zero
  always_comb begin
    store_data = rs2_data;
    store_strb = '0;
    case (funct3)
      f3_byte: begin
        store_data = {4{rs2_data[7:0]}};
        store_strb = 4'b0001 << addr[1:0];
      end
      f3_half: begin
        store_data = {2{rs2_data[15:0]}};
        if (!addr[0]) begin
          store_strb = addr[1] ? 4'b1100 : 4'b0011;
        end
      end
      f3_word: if (addr[1:0] == 2'b00) store_strb = 4'b1111;
      default: store_strb = '0;
    endcase
  end

  assign byte_lane = mem_rdata[{addr[1:0], 3'b000} +: 8];
  assign half_lane = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  // load side, misaligned returns zero
  always_comb begin
    load_data = '0;
    case (funct3)
      f3_byte:   load_data = {{24{byte_lane[7]}}, byte_lane};
      f3_byte_u: load_data = {24'h00_0000, byte_lane};
      f3_half:   if (!addr[0]) load_data = {{16{half_lane[15]}}, half_lane};
      f3_half_u: if (!addr[0]) load_data = {16'h0000, half_lane};
      f3_word:   if (addr[1:0] == 2'b00) load_data = mem_rdata;
      default:   load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                        clk,
  input  wire rv_core_pkg::reg_addr_t rs1_addr,
  input  wire rv_core_pkg::reg_addr_t rs2_addr,
  input  wire rv_core_pkg::reg_addr_t rd_addr,
  input  wire                        reg_we,
  input  wire rv_core_pkg::word_t    rd_data,
  output rv_core_pkg::word_t         rs1_data,
  output rv_core_pkg::word_t         rs2_data
);
  import rv_core_pkg::*;

  word_t regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (reg_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] strb_t;
  typedef logic [2:0] funct3_t;

  // rv32i base opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg    = 7'b011_0011,
    op_imm    = 7'b001_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_branch = 7'b110_0011,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_system = 7'b111_0011   // ebreak and friends
  } opcode_e;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store sizes
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  // register write-back source
  typedef enum logic [1:0] {
    wb_alu,
    wb_link,
    wb_load
  } wb_sel_e;

  localparam word_t default_reset_pc = 32'h8000_0000;

endpackage

`default_nettype wire

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter rv_core_pkg::word_t reset_pc = rv_core_pkg::default_reset_pc
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     mem_ack,
  input  wire rv_core_pkg::word_t mem_rdata,
  output logic                    mem_req,
  output logic                    mem_we,
  output rv_core_pkg::word_t      mem_addr,
  output rv_core_pkg::word_t      mem_wdata,
  output rv_core_pkg::strb_t      mem_wstrb,
  output rv_core_pkg::word_t      pc,
  output logic                    halted
);
  import rv_core_pkg::*;

  word_t     inst;
  funct3_t   funct3;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      reg_we;
  word_t     rd_data;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  word_t     sum;
  word_t     next_pc;
  word_t     link;
  word_t     load_data;
  word_t     store_data;
  strb_t     store_strb;
  logic      use_pc_a;
  logic      use_imm_b;
  logic      subtract;
  logic      is_branch;
  logic      is_jump;

  core_control #(
    .reset_pc (reset_pc)
  ) control0 (
    .clk        (clk),
    .reset      (reset),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .sum        (sum),
    .next_pc    (next_pc),
    .link       (link),
    .load_data  (load_data),
    .store_data (store_data),
    .store_strb (store_strb),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .inst       (inst),
    .funct3     (funct3),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rd_addr    (rd_addr),
    .reg_we     (reg_we),
    .wb_sel     (),          // consumed inside the controller by its rd_data mux
    .rd_data    (rd_data),
    .use_pc_a   (use_pc_a),
    .use_imm_b  (use_imm_b),
    .subtract   (subtract),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .pc         (pc),
    .halted     (halted)
  );

  register_file regs0 (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .reg_we   (reg_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  imm_gen imm0 (
    .inst (inst),
    .imm  (imm)
  );

  execute_unit exec0 (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .funct3    (funct3),
    .use_pc_a  (use_pc_a),
    .use_imm_b (use_imm_b),
    .subtract  (subtract),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .sum       (sum),
    .next_pc   (next_pc),
    .link      (link)
  );

  load_store_align lsu0 (
    .funct3     (funct3),
    .addr       (sum),
    .rs2_data   (rs2_data),
    .mem_rdata  (mem_rdata),
    .store_data (store_data),
    .store_strb (store_strb),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

// File: project.f
hdl/rv_core_pkg.sv
hdl/register_file.sv
hdl/imm_gen.sv
hdl/execute_unit.sv
hdl/load_store_align.sv
hdl/core_control.sv
hdl/rv_core_top.sv
test/tb_clock_gen.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

// File: test/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
  input wire                     clk,
  input wire                     reset,
  input wire                     mem_req,
  input wire                     mem_ack,
  input wire                     mem_we,
  input wire rv_core_pkg::word_t mem_addr,
  input wire rv_core_pkg::word_t mem_wdata,
  input wire rv_core_pkg::strb_t mem_wstrb,
  input wire                     halted
);

  int failure_count = 0;  // read by the testbench at the end of the run

  // request fields frozen while waiting for ack
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req && !mem_ack) |=> ($stable(mem_addr) && $stable(mem_we) &&
                               $stable(mem_wdata) && $stable(mem_wstrb)))
    else begin
      failure_count++;
      $error("bus fields changed during a pending request");
    end

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    (mem_req && !mem_ack) |=> mem_req)
    else begin
      failure_count++;
      $error("mem_req dropped before mem_ack");
    end

  a_req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_req) |-> !mem_ack)
    else begin
      failure_count++;
      $error("mem_req raised while mem_ack still high");
    end

  a_quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !mem_req)
    else begin
      failure_count++;
      $error("request while halted");
    end

endmodule

bind rv_core_top rv_core_checker checker0 (.*);

`default_nettype wire

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import rv_core_pkg::*;

  localparam word_t prog_base = default_reset_pc;
  localparam word_t data_base = 32'h8000_1000;
  localparam word_t sub_word  = 32'h80F1_7F82;  // preload for the load tests
  localparam int    max_delay = 6;              // random ack delay limit

  logic  clk;
  logic  por;
  logic  test_reset;
  logic  core_reset;
  logic  mem_req;
  logic  mem_we;
  logic  mem_ack;
  word_t mem_rdata;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t pc;
  logic  halted;

  word_t mem [word_t];
  strb_t wstrb_log [$];
  int    ack_delay_max;
  int    cur_delay;
  int    wait_cnt;
  int    n;                 // next program slot
  int    mismatch_count;
  int    other_errors;
  longint cycle_count;
  longint cycle_budget;
  string current_test;

  assign core_reset = por | test_reset;

  tb_clock_gen #(.period(100.0), .reset_cycles(5)) clkgen0 (.clk(clk), .reset(por));

  rv_core_top dut0 (
    .clk       (clk),
    .reset     (core_reset),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .pc        (pc),
    .halted    (halted)
  );

  function automatic word_t fill_word(word_t a);
    return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic word_t read_word(word_t a);
    word_t wa;
    wa = {a[31:2], 2'b00};
    return mem.exists(wa) ? mem[wa] : fill_word(wa);
  endfunction

  // four-phase memory responder with its own seeded ack delay stream
  initial begin
    word_t w;
    void'($urandom(91));
    forever begin
      @(posedge clk);
      if (core_reset) begin
        mem_ack  <= 1'b0;
        wait_cnt <= 0;
      end else if (mem_req && !mem_ack) begin
        if (wait_cnt >= cur_delay) begin
          w = read_word(mem_addr);
          if (mem_we) begin
            for (int i = 0; i < 4; i++) begin
              if (mem_wstrb[i]) w[8*i +: 8] = mem_wdata[8*i +: 8];
            end
            mem[{mem_addr[31:2], 2'b00}] = w;
            wstrb_log.push_back(mem_wstrb);
          end
          mem_rdata <= w;
          mem_ack   <= 1'b1;
          wait_cnt  <= 0;
          cur_delay <= (ack_delay_max == 0) ? 0 : $urandom_range(ack_delay_max, 0);
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end else if (!mem_req && mem_ack) begin
        mem_ack <= 1'b0;
      end
    end
  end

  // watchdog budget grows with every program started
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_budget) begin
      $display("Watchdog expired: test %s hung after %0d cycles", current_test, cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t enc_i(word_t imm, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(word_t imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(word_t imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(word_t imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic branch_rule(funct3_t f3, word_t a, word_t b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic compare_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic compare_strb(string name, strb_t exp, strb_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic compare_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic emit(word_t w);
    mem[prog_base + 4 * n] = w;
    n++;
  endtask

  task automatic new_program();
    mem.delete();
    wstrb_log.delete();
    n = 0;
    emit(enc_u(data_base[31:12], 10, op_lui));  // x10 = data pointer
  endtask

  // resets the core and checks the boot request, then waits out the halt
  task automatic run_program(string name);
    int cpi;
    cpi = 2 * (ack_delay_max + 3) + 2;
    current_test = name;
    cycle_budget = cycle_count + n * cpi * 2 + 60;
    @(posedge clk);
    test_reset <= 1'b1;
    repeat (5) @(posedge clk);
    test_reset <= 1'b0;
    @(negedge clk);
    compare_word("pc", default_reset_pc, pc);
    compare_bit("halted", 1'b0, halted);
    compare_bit("mem_req", 1'b0, mem_req);
    while (!mem_req) @(negedge clk);
    compare_word("mem_addr", default_reset_pc, mem_addr);
    compare_bit("mem_we", 1'b0, mem_we);
    compare_strb("mem_wstrb", 4'b0000, mem_wstrb);
    while (!halted) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      compare_bit("halted", 1'b1, halted);
      compare_bit("mem_req", 1'b0, mem_req);
    end
  endtask

  task automatic arithmetic_test(string name, int delay);
    int a;
    int b;
    a = 123;
    b = -45;
    ack_delay_max = delay;
    new_program();
    emit(enc_i(a, 0, 3'b000, 1, op_imm));
    emit(enc_i(b, 0, 3'b000, 2, op_imm));
    emit(enc_r(7'h00, 2, 1, 3'b000, 3));
    emit(enc_r(7'h20, 2, 1, 3'b000, 4));
    emit(enc_u(20'hABCDE, 5, op_lui));
    emit(enc_u(20'h00012, 6, op_auipc));   // slot 6
    emit(enc_i(5, 1, 3'b000, 0, op_imm));  // write to x0 is dropped
    emit(enc_r(7'h20, 1, 2, 3'b000, 7));
    for (int r = 0; r < 8; r++) begin
      emit(enc_s(4 * r, (r == 6) ? 0 : r + 1 - (r > 6), 10, f3_word));
    end
    emit(32'h0010_0073);
    run_program(name);
    compare_word("addi x1", a, read_word(data_base));
    compare_word("addi x2", b, read_word(data_base + 4));
    compare_word("add", a + b, read_word(data_base + 8));
    compare_word("sub", a - b, read_word(data_base + 12));
    compare_word("lui", 32'hABCDE000, read_word(data_base + 16));
    compare_word("auipc", prog_base + 24 + 32'h12000, read_word(data_base + 20));
    compare_word("x0", 32'h0, read_word(data_base + 24));
    compare_word("sub neg", b - a, read_word(data_base + 28));
  endtask

  task automatic control_flow_test();
    funct3_t   f3s [12];
    reg_addr_t ras [12];
    reg_addr_t rbs [12];
    word_t     rv [3];
    int        jal_idx;
    int        auipc_idx;
    int        target_idx;
    f3s = '{f3_beq, f3_beq, f3_bne, f3_bne, f3_blt, f3_blt,
            f3_bge, f3_bge, f3_bltu, f3_bltu, f3_bgeu, f3_bgeu};
    ras = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1};
    rbs = '{1, 2, 2, 1, 1, 2, 2, 1, 2, 1, 1, 2};
    rv  = '{32'h0, 32'd5, 32'hFFFF_FFFD};
    ack_delay_max = 0;
    new_program();
    emit(enc_i(5, 0, 3'b000, 1, op_imm));
    emit(enc_i(-3, 0, 3'b000, 2, op_imm));
    for (int k = 0; k < 12; k++) begin
      emit(enc_i(32'h7A, 0, 3'b000, 11 + k, op_imm));  // taken marker
      emit(enc_b(8, rbs[k], ras[k], f3s[k]));
      emit(enc_i(32'h0F, 0, 3'b000, 11 + k, op_imm));  // fall-through marker
    end
    emit(enc_i(32'h44, 0, 3'b000, 24, op_imm));
    jal_idx = n;
    emit(enc_j(8, 23));
    emit(enc_i(32'h55, 0, 3'b000, 24, op_imm));
    auipc_idx = n;
    emit(enc_u(20'h0, 25, op_auipc));
    emit(enc_i(13, 25, 3'b000, 26, op_jalr));  // odd target
    emit(enc_i(32'h66, 0, 3'b000, 24, op_imm));
    target_idx = n;
    emit(enc_u(20'h0, 27, op_auipc));          // jalr lands here
    for (int k = 0; k < 12; k++) emit(enc_s(4 * k, 11 + k, 10, f3_word));
    emit(enc_s(48, 23, 10, f3_word));
    emit(enc_s(52, 26, 10, f3_word));
    emit(enc_s(56, 24, 10, f3_word));
    emit(enc_s(60, 27, 10, f3_word));
    emit(32'h0010_0073);
    run_program("control_flow");
    for (int k = 0; k < 12; k++) begin
      compare_word($sformatf("branch %0d marker", k),
                   branch_rule(f3s[k], rv[ras[k]], rv[rbs[k]]) ? 32'h7A : 32'h0F,
                   read_word(data_base + 4 * k));
    end
    compare_word("jal link", prog_base + 4 * jal_idx + 4, read_word(data_base + 48));
    compare_word("jalr link", prog_base + 4 * (auipc_idx + 1) + 4, read_word(data_base + 52));
    compare_word("skipped paths", 32'h44, read_word(data_base + 56));
    compare_word("jalr target", prog_base + 4 * target_idx, read_word(data_base + 60));
  endtask

  task automatic sub_word_test();
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b3;
    logic [15:0] h1;
    word_t exp;
    b0 = sub_word[7:0];
    b1 = sub_word[15:8];
    b3 = sub_word[31:24];
    h1 = sub_word[31:16];
    ack_delay_max = 0;
    new_program();
    mem[data_base] = sub_word;
    emit(enc_i(0, 10, f3_byte, 1, op_load));
    emit(enc_i(0, 10, f3_byte_u, 2, op_load));
    emit(enc_i(1, 10, f3_byte, 3, op_load));
    emit(enc_i(2, 10, f3_half, 4, op_load));
    emit(enc_i(2, 10, f3_half_u, 5, op_load));
    emit(enc_i(0, 10, f3_half, 6, op_load));
    emit(enc_i(3, 10, f3_byte_u, 7, op_load));
    for (int r = 1; r <= 7; r++) emit(enc_s(12 + 4 * r, r, 10, f3_word));
    emit(enc_i(32'h1A5, 0, 3'b000, 8, op_imm));
    emit(enc_s(32'h41, 8, 10, f3_byte));
    emit(enc_s(32'h46, 8, 10, f3_half));
    emit(enc_s(32'h49, 8, 10, f3_half));   // misaligned half
    emit(32'h0010_0073);
    run_program("sub_word");
    compare_word("lb", {{24{b0[7]}}, b0}, read_word(data_base + 16));
    compare_word("lbu", {24'h0, b0}, read_word(data_base + 20));
    compare_word("lb +1", {{24{b1[7]}}, b1}, read_word(data_base + 24));
    compare_word("lh +2", {{16{h1[15]}}, h1}, read_word(data_base + 28));
    compare_word("lhu +2", {16'h0, h1}, read_word(data_base + 32));
    compare_word("lh", {{16{b1[7]}}, b1, b0}, read_word(data_base + 36));
    compare_word("lbu +3", {24'h0, b3}, read_word(data_base + 40));
    exp = fill_word(data_base + 32'h40);
    exp[15:8] = 8'hA5;
    compare_word("sb +0x41", exp, read_word(data_base + 32'h40));
    exp = fill_word(data_base + 32'h44);
    exp[31:16] = 16'h01A5;
    compare_word("sh +0x46", exp, read_word(data_base + 32'h44));
    compare_word("sh misaligned", fill_word(data_base + 32'h48), read_word(data_base + 32'h48));
    if (wstrb_log.size() != 10) begin
      $display("Store count wrong: saw %0d writes instead of 10", wstrb_log.size());
      other_errors++;
    end else begin
      for (int i = 0; i < 7; i++) compare_strb("sw strobes", 4'b1111, wstrb_log[i]);
      compare_strb("sb strobes", 4'b0010, wstrb_log[7]);
      compare_strb("sh strobes", 4'b1100, wstrb_log[8]);
      compare_strb("misaligned sh strobes", 4'b0000, wstrb_log[9]);
    end
  endtask

  task automatic illegal_opcode_test();
    ack_delay_max = 0;
    new_program();
    emit(enc_i(32'h3C, 0, 3'b000, 1, op_imm));
    emit(enc_s(0, 1, 10, f3_word));
    emit(32'h0000_007F);   // no such opcode
    emit(enc_s(4, 1, 10, f3_word));
    run_program("illegal_opcode");
    compare_word("store before halt", 32'h3C, read_word(data_base));
    compare_word("store after halt", fill_word(data_base + 4), read_word(data_base + 4));
  endtask

  initial begin
    test_reset = 1'b0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    cur_delay = 0;
    wait_cnt = 0;
    ack_delay_max = 0;
    mismatch_count = 0;
    other_errors = 0;
    cycle_count = 0;
    cycle_budget = 100;
    current_test = "power_on";
    arithmetic_test("arithmetic", 0);
    control_flow_test();
    sub_word_test();
    arithmetic_test("back_pressure", max_delay);
    illegal_opcode_test();
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_errors, dut0.checker0.failure_count);
    if (mismatch_count == 0 && other_errors == 0 && dut0.checker0.failure_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter realtime period       = 100.0,
  parameter int      reset_cycles = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  // power-on reset, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire
